// ==== dpc_pkg.sv ====
/*
 * Shared geometry, widths and types of the bad pixel detector.
 * Import it into every design unit that needs a constant or a type.
 */

package dpc_pkg;

  // frame geometry, kept small for simulation
  localparam int FRAME_WIDTH    = 16;
  localparam int FRAME_HEIGHT   = 8;

  localparam int K_WIDTH        = 16;
  localparam int COORD_WIDTH    = 10;

  // bad pixel list
  localparam int BP_LIST_DEPTH  = 16;
  localparam int BP_ADDR_WIDTH  = 4;
  localparam int BP_COUNT_WIDTH = 5;

  typedef logic [K_WIDTH-1:0]        k_t;
  typedef logic [COORD_WIDTH-1:0]    coord_t;
  typedef logic [BP_ADDR_WIDTH-1:0]  bp_addr_t;
  typedef logic [BP_COUNT_WIDTH-1:0] bp_count_t;
  typedef logic [31:0]               bp_entry_t;  // {y, x}, 16 bits each

  // raster positions that mark the frame edges and the end of the flush
  localparam coord_t X_LAST      = coord_t'(FRAME_WIDTH - 1);
  localparam coord_t Y_LAST      = coord_t'(FRAME_HEIGHT - 1);
  localparam coord_t Y_FLUSH_END = coord_t'(FRAME_HEIGHT + 1);

  typedef enum logic
  {
    ST_STREAM,
    ST_FLUSH
  } tagger_state_t;

endpackage

// ==== k_stream_if.sv ====
/*
 * One row of the tagged k stream: a beat strobe, the k value, its dead
 * flag and the raster position of the newest beat.
 */

interface k_stream_if;
  import dpc_pkg::*;

  logic   valid;
  k_t     k;
  logic   dead;    // k is zero
  coord_t x;
  coord_t y;

  modport source
  (
    output valid, k, dead, x, y
  );

  modport sink
  (
    input valid, k, dead, x, y
  );

endinterface

// ==== raster_tagger.sv ====
/*
 * Registers the incoming k beats and tags them with their raster position.
 * After the last pixel of a frame it emits FRAME_WIDTH+1 flush beats so
 * the bottom row of windows completes without new input.
 */

module raster_tagger
(
  input  logic        aclk,
  input  logic        aresetn,
  input  logic        k_valid,
  input  dpc_pkg::k_t k_data,
  input  logic        k_sof,
  k_stream_if.source  out
);
  import dpc_pkg::*;

  tagger_state_t state;
  coord_t        nx;     // position of the next beat
  coord_t        ny;
  coord_t        px;     // position given to the beat taken now
  coord_t        py;
  logic          take;

  assign take = (state == ST_FLUSH) || k_valid;

  // sof only restarts the raster while streaming
  always_comb
  begin
    if (state == ST_STREAM && k_sof)
    begin
      px = '0;
      py = '0;
    end
    else
    begin
      px = nx;
      py = ny;
    end
  end

  // ==========================================================================
  // raster counters and flush control
  // ==========================================================================
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state     <= ST_STREAM;
      nx        <= '0;
      ny        <= '0;
      out.valid <= 1'b0;
    end
    else
    begin
      out.valid <= take;
      if (take)
      begin
        if (px == X_LAST)
        begin
          nx <= '0;
          ny <= py + coord_t'(1);
        end
        else
        begin
          nx <= px + coord_t'(1);
          ny <= py;
        end

        case (state)
          ST_STREAM:
          begin
            if (px == X_LAST && py == Y_LAST)
            begin
              state <= ST_FLUSH;
            end
          end
          ST_FLUSH:
          begin
            // (0, H+1) is the last flush beat
            if (py == Y_FLUSH_END)
            begin
              state <= ST_STREAM;
              nx    <= '0;
              ny    <= '0;
            end
          end
          default: state <= ST_STREAM;
        endcase
      end
    end
  end

  // beat payload
  always_ff @(posedge aclk)
  begin
    if (take)
    begin
      out.k    <= (state == ST_FLUSH) ? '0 : k_data;
      out.dead <= (state == ST_FLUSH) || (k_data == '0);
      out.x    <= px;
      out.y    <= py;
    end
  end

endmodule

// ==== k_line_delay.sv ====
/*
 * Delays k and the dead flag by one frame row (FRAME_WIDTH valid beats).
 * The strobe and the position of the newest beat pass through as they are.
 */

module k_line_delay
(
  input  logic       aclk,
  input  logic       aresetn,
  k_stream_if.sink   in,
  k_stream_if.source out
);
  import dpc_pkg::*;

  k_t                     k_mem [FRAME_WIDTH];
  logic [FRAME_WIDTH-1:0] dead_sr;

  // shift memory for k, moves only on beats
  always_ff @(posedge aclk)
  begin
    if (in.valid)
    begin
      k_mem[0] <= in.k;
      for (int i = 1; i < FRAME_WIDTH; i++)
      begin
        k_mem[i] <= k_mem[i-1];
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      dead_sr <= '0;
    end
    else if (in.valid)
    begin
      dead_sr <= {dead_sr[FRAME_WIDTH-2:0], in.dead};
    end
  end

  assign out.valid = in.valid;
  assign out.x     = in.x;
  assign out.y     = in.y;
  assign out.k     = k_mem[FRAME_WIDTH-1];      // FRAME_WIDTH beats old
  assign out.dead  = dead_sr[FRAME_WIDTH-1];

endmodule

// ==== window_median.sv ====
/*
 * Builds the reflected 3x3 k window from three rows, takes the median of
 * the nonzero neighbors and flags bad pixels. Three pipeline stages, the
 * window centered at (cx, cy) enters on the row-0 beat after (cx+1, cy+1).
 */

module window_median
(
  input  logic            aclk,
  input  logic            aresetn,
  k_stream_if.sink        rows [0:2],
  input  dpc_pkg::k_t     k_threshold,
  output logic            bp_hit,
  output dpc_pkg::coord_t hit_x,
  output dpc_pkg::coord_t hit_y,
  output logic            frame_end
);
  import dpc_pkg::*;

  // per row: current beat and the two before it, row 2 holds the oldest data
  k_t         cur_k     [3];
  logic       cur_dead  [3];
  k_t         tap1_k    [3];
  logic       tap1_dead [3];
  k_t         tap2_k    [3];
  logic       tap2_dead [3];
  k_t         col_k     [3][3];   // [row][left, center, right]
  logic       col_dead  [3][3];

  logic       beat;
  coord_t     cx;
  coord_t     cy;
  logic       center_ok;
  logic       cx_first;
  logic       cx_last;
  logic       cy_first;
  logic       cy_last;

  // stage registers
  logic       s1_valid;
  logic       s1_last;
  coord_t     s1_x;
  coord_t     s1_y;
  k_t         s1_k    [3][3];
  logic       s1_dead [3][3];

  k_t         nb_k [8];
  logic [3:0] nb_n;

  logic       s2_valid;
  logic       s2_last;
  coord_t     s2_x;
  coord_t     s2_y;
  k_t         s2_k [8];
  logic [3:0] s2_n;
  k_t         s2_ck;
  logic       s2_cdead;

  logic [2:0] mid_idx;
  logic [2:0] rank;
  k_t         med;
  k_t         dev;
  logic       bad;

  for (genvar r = 0; r < 3; r++)
  begin : g_row
    assign cur_k[r]    = rows[r].k;
    assign cur_dead[r] = rows[r].dead;
  end

  assign beat = rows[0].valid;

  // ==========================================================================
  // stage 1: center position, column taps, edge reflection
  // ==========================================================================
  always_comb
  begin
    if (rows[0].x == '0)
    begin
      cx        = X_LAST;          // wrapped to the start of the next row
      cy        = rows[0].y - coord_t'(2);
      center_ok = (rows[0].y > coord_t'(1)) && (rows[0].y <= Y_FLUSH_END);
    end
    else
    begin
      cx        = rows[0].x - coord_t'(1);
      cy        = rows[0].y - coord_t'(1);
      center_ok = (rows[0].y != '0) && (rows[0].y < Y_FLUSH_END);
    end
  end

  assign cx_first = (cx == '0);
  assign cx_last  = (cx == X_LAST);
  assign cy_first = (cy == '0);
  assign cy_last  = (cy == Y_LAST);

  // column -1 reads column 1, column W reads column W-2
  always_comb
  begin
    for (int r = 0; r < 3; r++)
    begin
      col_k[r][0]    = cx_first ? cur_k[r] : tap2_k[r];
      col_dead[r][0] = cx_first ? cur_dead[r] : tap2_dead[r];
      col_k[r][1]    = tap1_k[r];
      col_dead[r][1] = tap1_dead[r];
      col_k[r][2]    = cx_last ? tap2_k[r] : cur_k[r];
      col_dead[r][2] = cx_last ? tap2_dead[r] : cur_dead[r];
    end
  end

  always_ff @(posedge aclk)
  begin
    if (beat)
    begin
      for (int r = 0; r < 3; r++)
      begin
        tap1_k[r]    <= cur_k[r];
        tap1_dead[r] <= cur_dead[r];
        tap2_k[r]    <= tap1_k[r];
        tap2_dead[r] <= tap1_dead[r];
      end
    end
    // window rows top to bottom, row -1 and row H reflected
    for (int c = 0; c < 3; c++)
    begin
      s1_k[0][c]    <= cy_first ? col_k[0][c] : col_k[2][c];
      s1_dead[0][c] <= cy_first ? col_dead[0][c] : col_dead[2][c];
      s1_k[1][c]    <= col_k[1][c];
      s1_dead[1][c] <= col_dead[1][c];
      s1_k[2][c]    <= cy_last ? col_k[2][c] : col_k[0][c];
      s1_dead[2][c] <= cy_last ? col_dead[2][c] : col_dead[0][c];
    end
    s1_x <= cx;
    s1_y <= cy;
  end

  // ==========================================================================
  // stage 2: compact the nonzero neighbors
  // ==========================================================================
  always_comb
  begin
    nb_n = '0;
    for (int i = 0; i < 8; i++)
    begin
      nb_k[i] = '0;
    end
    for (int r = 0; r < 3; r++)
    begin
      for (int c = 0; c < 3; c++)
      begin
        if ((r != 1 || c != 1) && !s1_dead[r][c])
        begin
          nb_k[nb_n[2:0]] = s1_k[r][c];
          nb_n            = nb_n + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    s2_k     <= nb_k;
    s2_n     <= nb_n;
    s2_ck    <= s1_k[1][1];
    s2_cdead <= s1_dead[1][1];
    s2_x     <= s1_x;
    s2_y     <= s1_y;
  end

  // ==========================================================================
  // stage 3: rank for the median, compare with the center
  // ==========================================================================
  assign mid_idx = 3'((s2_n - 4'd1) >> 1);   // lower median

  always_comb
  begin
    med  = '0;
    rank = '0;
    for (int i = 0; i < 8; i++)
    begin
      rank = '0;
      for (int j = 0; j < 8; j++)
      begin
        // ties broken by position, so every rank is unique
        if (4'(j) < s2_n && (s2_k[j] < s2_k[i] || (s2_k[j] == s2_k[i] && j < i)))
        begin
          rank = rank + 3'd1;
        end
      end
      if (4'(i) < s2_n && rank == mid_idx)
      begin
        med = s2_k[i];
      end
    end
  end

  assign dev = (s2_ck >= med) ? s2_ck - med : med - s2_ck;
  assign bad = s2_cdead || (s2_n != '0 && dev > k_threshold);

  // control path
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      s1_valid  <= 1'b0;
      s1_last   <= 1'b0;
      s2_valid  <= 1'b0;
      s2_last   <= 1'b0;
      bp_hit    <= 1'b0;
      frame_end <= 1'b0;
    end
    else
    begin
      s1_valid  <= beat && center_ok;
      s1_last   <= beat && center_ok && cx_last && cy_last;
      s2_valid  <= s1_valid;
      s2_last   <= s1_last;
      bp_hit    <= s2_valid && bad;
      frame_end <= s2_valid && s2_last;
    end
  end

  always_ff @(posedge aclk)
  begin
    hit_x <= s2_x;
    hit_y <= s2_y;
  end

endmodule

// ==== bp_list.sv ====
/*
 * Bad pixel list. Stores the first BP_LIST_DEPTH hits of a frame, counts
 * them and serves a registered read port for software.
 */

module bp_list
(
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               bp_hit,
  input  dpc_pkg::coord_t    hit_x,
  input  dpc_pkg::coord_t    hit_y,
  input  logic               frame_end,
  output logic               bp_valid,
  output dpc_pkg::coord_t    bp_x,
  output dpc_pkg::coord_t    bp_y,
  output logic               frame_done,
  output dpc_pkg::bp_count_t bp_count,
  input  dpc_pkg::bp_addr_t  rd_addr,
  output dpc_pkg::bp_entry_t rd_data
);
  import dpc_pkg::*;

  bp_entry_t mem [BP_LIST_DEPTH];
  logic      fresh;     // previous frame closed, next event starts from zero
  bp_count_t base;
  logic      full;

  // the old count stays readable until the new frame reports something
  assign base = fresh ? '0 : bp_count;
  assign full = (base == bp_count_t'(BP_LIST_DEPTH));

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bp_valid   <= 1'b0;
      frame_done <= 1'b0;
      bp_count   <= '0;
      fresh      <= 1'b0;
    end
    else
    begin
      bp_valid   <= bp_hit;    // pulses even when the list is full
      frame_done <= frame_end;
      if (bp_hit || frame_end)
      begin
        bp_count <= (bp_hit && !full) ? base + bp_count_t'(1) : base;
        fresh    <= frame_end;
      end
    end
  end

  // ==========================================================================
  // list memory and read port
  // ==========================================================================
  always_ff @(posedge aclk)
  begin
    if (bp_hit)
    begin
      bp_x <= hit_x;
      bp_y <= hit_y;
    end
    if (bp_hit && !full)
    begin
      mem[bp_addr_t'(base)] <= {16'(hit_y), 16'(hit_x)};
    end
  end

  always_ff @(posedge aclk)
  begin
    rd_data <= ({1'b0, rd_addr} < bp_count) ? mem[rd_addr] : '0;  // empty slots read 0
  end

endmodule

// ==== dpc_detector.sv ====
/*
 * Top level of the bad pixel detector. k values enter one per beat in
 * raster order; bad pixel positions come out as pulses and in a list.
 */

module dpc_detector
(
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               k_valid,
  input  dpc_pkg::k_t        k_data,
  input  logic               k_sof,
  input  dpc_pkg::k_t        k_threshold,
  output logic               bp_valid,
  output dpc_pkg::coord_t    bp_x,
  output dpc_pkg::coord_t    bp_y,
  output logic               frame_done,
  output dpc_pkg::bp_count_t bp_count,
  input  dpc_pkg::bp_addr_t  rd_addr,
  output dpc_pkg::bp_entry_t rd_data
);
  import dpc_pkg::*;

  // row 0 newest, row 2 two frame rows back
  k_stream_if row [0:2] ();

  logic   bp_hit;
  coord_t hit_x;
  coord_t hit_y;
  logic   frame_end;

  raster_tagger i_raster_tagger
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .k_valid (k_valid),
    .k_data  (k_data),
    .k_sof   (k_sof),
    .out     (row[0])
  );

  for (genvar i = 0; i < 2; i++)
  begin : g_line
    k_line_delay i_k_line_delay
    (
      .aclk    (aclk),
      .aresetn (aresetn),
      .in      (row[i]),
      .out     (row[i+1])
    );
  end

  window_median i_window_median
  (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .rows        (row),
    .k_threshold (k_threshold),
    .bp_hit      (bp_hit),
    .hit_x       (hit_x),
    .hit_y       (hit_y),
    .frame_end   (frame_end)
  );

  bp_list i_bp_list
  (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .bp_hit     (bp_hit),
    .hit_x      (hit_x),
    .hit_y      (hit_y),
    .frame_end  (frame_end),
    .bp_valid   (bp_valid),
    .bp_x       (bp_x),
    .bp_y       (bp_y),
    .frame_done (frame_done),
    .bp_count   (bp_count),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

endmodule

// ==== dpc_detector_properties.sv ====
/*
 * Concurrent checks on the detector ports. Bound into dpc_detector.
 */

module dpc_detector_properties
(
  input logic               aclk,
  input logic               aresetn,
  input logic               bp_valid,
  input dpc_pkg::coord_t    bp_x,
  input logic               frame_done,
  input dpc_pkg::bp_count_t bp_count
);
  import dpc_pkg::*;

  count_in_range: assert property (@(posedge aclk) disable iff (!aresetn)
    bp_count <= bp_count_t'(BP_LIST_DEPTH))
    else $error("bp_count above the list depth");

  hit_x_in_frame: assert property (@(posedge aclk) disable iff (!aresetn)
    bp_valid |-> bp_x < coord_t'(FRAME_WIDTH))
    else $error("bp_x outside the frame on a hit");

  // one pulse per frame
  done_one_cycle: assert property (@(posedge aclk) disable iff (!aresetn)
    frame_done |=> !frame_done)
    else $error("frame_done longer than one cycle");

  no_hit_in_reset: assert property (@(posedge aclk)
    !aresetn |=> !bp_valid)
    else $error("bp_valid high during reset");

endmodule

bind dpc_detector dpc_detector_properties i_dpc_detector_properties
(
  .aclk       (aclk),
  .aresetn    (aresetn),
  .bp_valid   (bp_valid),
  .bp_x       (bp_x),
  .frame_done (frame_done),
  .bp_count   (bp_count)
);

// ==== dpc_detector_tb.sv ====
/*
 * Testbench for the bad pixel detector. Streams random k frames with planted
 * dead pixels and outliers, predicts the bad list with a model and checks
 * the hit pulses, the per-frame count and the list read-back.
 */

module dpc_detector_tb;
  import dpc_pkg::*;

  localparam int NUM_FRAMES = 6;
  localparam int GAP_CYCLES = FRAME_WIDTH + 4;
  localparam int RD_CYCLES  = BP_LIST_DEPTH + 2;
  localparam int MAX_CYCLES = 16 + 100
                            + NUM_FRAMES * (FRAME_WIDTH * FRAME_HEIGHT + GAP_CYCLES
                                            + RD_CYCLES + 16);

  logic      aclk = 1'b0;
  logic      aresetn;
  logic      k_valid;
  k_t        k_data;
  logic      k_sof;
  k_t        k_threshold;
  logic      bp_valid;
  coord_t    bp_x;
  coord_t    bp_y;
  logic      frame_done;
  bp_count_t bp_count;
  bp_addr_t  rd_addr;
  bp_entry_t rd_data;

  integer    seed;
  int        frame_k [FRAME_HEIGHT][FRAME_WIDTH];
  int        thr_val;
  int        exp_x [$];          // expected hits in raster order
  int        exp_y [$];
  bp_entry_t exp_list [BP_LIST_DEPTH];
  int        exp_total;
  int        done_count = 0;
  int        cycles = 0;
  string     test_name;

  always #20 aclk = ~aclk;

  dpc_detector i_dpc_detector
  (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .k_valid     (k_valid),
    .k_data      (k_data),
    .k_sof       (k_sof),
    .k_threshold (k_threshold),
    .bp_valid    (bp_valid),
    .bp_x        (bp_x),
    .bp_y        (bp_y),
    .frame_done  (frame_done),
    .bp_count    (bp_count),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  task automatic fail_and_stop(string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // edge reflection maps -1 to 1 and n to n-2
  function automatic int reflect(int i, int n);
    if (i < 0)
      return 1;
    if (i >= n)
      return n - 2;
    return i;
  endfunction

  // ==========================================================================
  // reference model
  // ==========================================================================
  task automatic build_expected();
    int nb [8];
    int n;
    int t;
    int med;
    int dev;
    exp_total = 0;
    for (int a = 0; a < BP_LIST_DEPTH; a++)
      exp_list[a] = '0;
    for (int y = 0; y < FRAME_HEIGHT; y++)
    begin
      for (int x = 0; x < FRAME_WIDTH; x++)
      begin
        n = 0;
        for (int dy = -1; dy <= 1; dy++)
        begin
          for (int dx = -1; dx <= 1; dx++)
          begin
            t = frame_k[reflect(y + dy, FRAME_HEIGHT)][reflect(x + dx, FRAME_WIDTH)];
            if ((dy != 0 || dx != 0) && t != 0)
            begin
              nb[n] = t;
              n++;
            end
          end
        end
        for (int i = 1; i < n; i++)         // ascending insertion sort
        begin
          for (int j = i; j > 0 && nb[j-1] > nb[j]; j--)
          begin
            t       = nb[j];
            nb[j]   = nb[j-1];
            nb[j-1] = t;
          end
        end
        med = (n > 0) ? nb[(n - 1) / 2] : 0;
        dev = frame_k[y][x] - med;
        if (dev < 0)
          dev = -dev;
        if (frame_k[y][x] == 0 || (n > 0 && dev > thr_val))
        begin
          exp_x.push_back(x);
          exp_y.push_back(y);
          if (exp_total < BP_LIST_DEPTH)
            exp_list[exp_total] = {16'(y), 16'(x)};
          exp_total++;
        end
      end
    end
  endtask

  // plant selects nothing (0), dead corners and edges (1) or row 1 and column 1 deviations (2)
  task automatic run_frame(string name, int thr_min, int zero_n, int out_n, int plant);
    int base;
    int pick;
    int exp_count;
    test_name = name;
    base      = 800 + ($random(seed) & 511);
    thr_val   = thr_min + ($random(seed) & 15);
    for (int y = 0; y < FRAME_HEIGHT; y++)
    begin
      for (int x = 0; x < FRAME_WIDTH; x++)
      begin
        frame_k[y][x] = base + ($random(seed) & 31) - 16;
        pick          = $random(seed) & 63;
        if (pick < zero_n)
          frame_k[y][x] = 0;
        else if (pick < zero_n + out_n)
          frame_k[y][x] = (pick & 1) ? base + 80 + ($random(seed) & 127)
                                     : base - 80 - ($random(seed) & 127);
      end
    end
    if (plant == 1)
    begin
      frame_k[0][0]                            = 0;
      frame_k[0][FRAME_WIDTH-1]                = 0;
      frame_k[FRAME_HEIGHT-1][0]               = 0;
      frame_k[FRAME_HEIGHT-1][FRAME_WIDTH-1]   = 0;
      frame_k[0][7]                            = 0;
      frame_k[3][0]                            = 0;
      frame_k[4][FRAME_WIDTH-1]                = 0;
      frame_k[FRAME_HEIGHT-1][9]               = 0;
    end
    else if (plant == 2)
    begin
      for (int i = 3; i <= 5; i++)
      begin
        frame_k[1][i] = base + 300;  // seen twice by row 0 windows
        frame_k[i][1] = base + 300;  // seen twice by column 0 windows
      end
    end
    build_expected();
    exp_count = (exp_total < BP_LIST_DEPTH) ? exp_total : BP_LIST_DEPTH;

    @(negedge aclk);
    k_threshold = k_t'(thr_val);
    for (int y = 0; y < FRAME_HEIGHT; y++)
    begin
      for (int x = 0; x < FRAME_WIDTH; x++)
      begin
        k_valid = 1'b1;
        k_data  = k_t'(frame_k[y][x]);
        k_sof   = (x == 0 && y == 0);
        @(negedge aclk);
      end
    end
    k_valid = 1'b0;
    k_sof   = 1'b0;
    k_data  = '0;

    // idle while the flush beats finish the bottom row
    while (frame_done !== 1'b1)
      @(negedge aclk);
    assert (bp_count == bp_count_t'(exp_count))
      else fail_and_stop($sformatf("ERR %s count expected %0d actual %0d",
                                   test_name, exp_count, bp_count));

    for (int a = 0; a < BP_LIST_DEPTH; a++)
    begin
      rd_addr = bp_addr_t'(a);
      @(negedge aclk);
      assert (rd_data == exp_list[a])
        else fail_and_stop($sformatf("ERR %s list[%0d] expected %08h actual %08h",
                                     test_name, a, exp_list[a], rd_data));
    end
    assert (exp_x.size() == 0)
      else fail_and_stop($sformatf("%s: %0d bad pixels were never reported",
                                   test_name, exp_x.size()));
  endtask

  // ==========================================================================
  // hit monitor and timeout
  // ==========================================================================
  always @(negedge aclk)
  begin
    if (aresetn && bp_valid)
    begin
      assert (exp_x.size() > 0)
        else fail_and_stop($sformatf("%s: bad pixel pulse at (%0d,%0d) with none expected",
                                     test_name, bp_x, bp_y));
      assert (bp_x == coord_t'(exp_x[0]) && bp_y == coord_t'(exp_y[0]))
        else fail_and_stop($sformatf("ERR %s hit expected (%0d,%0d) actual (%0d,%0d)",
                                     test_name, exp_x[0], exp_y[0], bp_x, bp_y));
      void'(exp_x.pop_front());
      void'(exp_y.pop_front());
    end
    if (aresetn && frame_done)
      done_count++;
  end

  always @(posedge aclk)
  begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    seed        = 32'he9cb;
    aresetn     = 1'b0;
    k_valid     = 1'b0;
    k_data      = '0;
    k_sof       = 1'b0;
    k_threshold = '0;
    rd_addr     = '0;
    repeat (16) @(negedge aclk);
    aresetn = 1'b1;

    run_frame("random", 24, 3, 3, 0);
    run_frame("corners", 24, 1, 2, 1);
    run_frame("reflection", 40, 0, 0, 2);
    run_frame("saturate", 24, 18, 4, 0);
    run_frame("zero_neighbors", 8, 10, 2, 0);
    run_frame("restart", 30, 2, 2, 0);      // count must start again from zero

    if (done_count == NUM_FRAMES)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      $display("frame_done pulsed %0d times for %0d frames", done_count, NUM_FRAMES);
      $display("Result: FAILED");
      $fatal(1, "frame count mismatch");
    end
  end

endmodule

// ==== all.f ====
dpc_pkg.sv
k_stream_if.sv
raster_tagger.sv
k_line_delay.sv
window_median.sv
bp_list.sv
dpc_detector.sv
dpc_detector_properties.sv
dpc_detector_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dpc_detector_tb
FILELIST  := all.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
